/* l1d_top.f */
rtl/l1d_pkg.sv
rtl/l1d_ways.sv
rtl/l1d_ctrl.sv
rtl/l1d_top.sv
sim/l1d_mem_model.sv
sim/l1d_sva.sv
sim/l1d_tb.sv

/* Bender.yml */
package:
  name: l1d_cache

sources:
  - files:
      - rtl/l1d_pkg.sv
      - rtl/l1d_ways.sv
      - rtl/l1d_ctrl.sv
      - rtl/l1d_top.sv
  - target: simulation
    files:
      - sim/l1d_mem_model.sv
      - sim/l1d_sva.sv
      - sim/l1d_tb.sv

/* sim/l1d_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module l1d_tb
    import l1d_pkg::*;
();

    localparam int NUM_ENTRIES = 10;
    localparam int MAX_CYCLES  = 40 * NUM_ENTRIES + 40;

    logic              clk;
    logic              rstn;
    logic              req_valid;
    logic              req_ready;
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    logic [WORD_W-1:0] req_wdata;
    logic              rsp_valid;
    logic [WORD_W-1:0] rsp_rdata;
    logic              rsp_ready;
    logic              mem_req_valid;
    logic              mem_req_ready;
    logic              mem_req_write;
    logic [ADDR_W-1:0] mem_req_addr;
    logic [LINE_W-1:0] mem_req_wdata;
    logic              mem_rsp_valid;
    logic [LINE_W-1:0] mem_rsp_rdata;
    logic              mem_rsp_ready;
    logic [ADDR_W-1:0] refill_addr;
    int                refill_cnt;
    int                wb_cnt;
    logic [ADDR_W-1:0] peek_addr;
    logic [WORD_W-1:0] peek_word;

    // Stimulus table
    string             t_name  [NUM_ENTRIES];
    logic              t_write [NUM_ENTRIES];
    logic [ADDR_W-1:0] t_addr  [NUM_ENTRIES];
    logic [WORD_W-1:0] t_wdata [NUM_ENTRIES];
    logic [WORD_W-1:0] t_exp   [NUM_ENTRIES];
    int                t_hold  [NUM_ENTRIES];
    int                n_entries;
    logic [WORD_W-1:0] shadow  [1024];
    int                cycles = 0;

    l1d_top UUT (
        .clk_i(clk), .rstn_i(rstn),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_write_i(req_write),
        .req_addr_i(req_addr), .req_wdata_i(req_wdata),
        .rsp_valid_o(rsp_valid), .rsp_rdata_o(rsp_rdata), .rsp_ready_i(rsp_ready),
        .mem_req_valid_o(mem_req_valid), .mem_req_ready_i(mem_req_ready),
        .mem_req_write_o(mem_req_write), .mem_req_addr_o(mem_req_addr),
        .mem_req_wdata_o(mem_req_wdata), .mem_rsp_valid_i(mem_rsp_valid),
        .mem_rsp_rdata_i(mem_rsp_rdata), .mem_rsp_ready_o(mem_rsp_ready)
    );

    l1d_mem_model u_mem (
        .clk_i(clk), .rstn_i(rstn),
        .mem_req_valid_i(mem_req_valid), .mem_req_ready_o(mem_req_ready),
        .mem_req_write_i(mem_req_write), .mem_req_addr_i(mem_req_addr),
        .mem_req_wdata_i(mem_req_wdata), .mem_rsp_valid_o(mem_rsp_valid),
        .mem_rsp_rdata_o(mem_rsp_rdata), .mem_rsp_ready_i(mem_rsp_ready),
        .refill_addr_o(refill_addr), .refill_cnt_o(refill_cnt), .wb_cnt_o(wb_cnt),
        .peek_addr_i(peek_addr), .peek_word_o(peek_word)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end else if (UUT.u_sva.fail_cnt != 0) begin
            $display("A bound assertion failed");
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    // Word w of line L holds L + 4w, XOR A5A5_0000
    function automatic logic [WORD_W-1:0] pattern_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] line;
        line = {addr[ADDR_W-1:4], 4'h0};
        return (line + 32'(addr[3:2]) * 4) ^ 32'hA5A5_0000;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic add_entry(input string name, input logic write, input logic [ADDR_W-1:0] addr,
                             input logic [WORD_W-1:0] wdata, input int hold);
        t_name[n_entries]  = name;
        t_write[n_entries] = write;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_hold[n_entries]  = hold;
        if (write) begin
            shadow[addr[11:2]] = wdata;
            t_exp[n_entries]   = '0;
        end else begin
            t_exp[n_entries] = shadow[addr[11:2]];
        end
        n_entries++;
    endtask

    task automatic build_table();
        n_entries = 0;
        for (int a = 0; a < 1024; a++) begin
            shadow[a] = pattern_word(32'(a * 4));
        end
        add_entry("rd_miss",        1'b0, 32'h0000_0104, 32'h0,         0);
        add_entry("wr_miss",        1'b1, 32'h0000_0208, 32'hDEAD_BEEF, 0);
        add_entry("rd_written",     1'b0, 32'h0000_0208, 32'h0,         1);
        add_entry("rd_hit_word",    1'b0, 32'h0000_020C, 32'h0,         0);
        // Three tags into set 3
        add_entry("wr_set3_a",      1'b1, 32'h0000_0030, 32'h1111_1111, 0);
        add_entry("wr_set3_b",      1'b1, 32'h0000_00B4, 32'h2222_2222, 0);
        add_entry("wr_set3_evict",  1'b1, 32'h0000_0138, 32'h3333_3333, 0);
        add_entry("rd_after_evict", 1'b0, 32'h0000_0030, 32'h0,         0);
        add_entry("rd_hold",        1'b0, 32'h0000_003C, 32'h0,         4);
        add_entry("rd_refetch",     1'b0, 32'h0000_00B4, 32'h0,         2);
    endtask

    task automatic run_entry(input int i);
        int refills;
        int lat;
        refills   = refill_cnt;
        req_valid <= 1'b1;
        req_write <= t_write[i];
        req_addr  <= t_addr[i];
        req_wdata <= t_wdata[i];
        @(posedge clk);
        while (!req_ready) begin
            @(posedge clk);
        end
        req_valid <= 1'b0;
        lat = 0;
        if (t_write[i]) begin
            do begin
                @(posedge clk);
            end while (!req_ready);
        end else begin
            do begin
                @(posedge clk);
                lat++;
            end while (!rsp_valid);
            // Seen one edge after it rises, so a hit rising at A+2 counts 3
            if (refill_cnt == refills) begin
                check_value({t_name[i], "_hit_latency"}, 32'd3, 32'(lat));
            end
            repeat (t_hold[i]) begin
                check_value(t_name[i], t_exp[i], rsp_rdata);
                check_value({t_name[i], "_req_ready"}, 32'd0, 32'(req_ready));
                @(posedge clk);
            end
            check_value(t_name[i], t_exp[i], rsp_rdata);
            check_value({t_name[i], "_req_ready"}, 32'd0, 32'(req_ready));
            rsp_ready <= 1'b1;
            @(posedge clk);
            check_value({t_name[i], "_rsp_valid"}, 32'd1, 32'(rsp_valid));
            rsp_ready <= 1'b0;
        end
        if (refill_cnt != refills) begin
            check_value({t_name[i], "_refill_addr"}, {t_addr[i][ADDR_W-1:4], 4'h0}, refill_addr);
        end
    endtask

    task automatic peek_memory(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] word);
        peek_addr <= addr;
        @(posedge clk);
        @(posedge clk);
        word = peek_word;
    endtask

    initial begin
        logic [WORD_W-1:0] word;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        rsp_ready = 1'b0;
        peek_addr = '0;
        build_table();
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        check_value("reset_req_ready", 32'd1, 32'(req_ready));
        check_value("reset_rsp_valid", 32'd0, 32'(rsp_valid));
        check_value("reset_mem_req_valid", 32'd0, 32'(mem_req_valid));
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        // Evicted dirty lines must now sit in memory
        peek_memory(32'h0000_0030, word);
        check_value("mem_set3_a", shadow[10'h00C], word);
        peek_memory(32'h0000_00B4, word);
        check_value("mem_set3_b", shadow[10'h02D], word);
        peek_memory(32'h0000_0138, word);
        check_value("mem_set3_evict", shadow[10'h04E], word);
        // One write-back per dirty victim in set 3
        check_value("wb_count", 32'd3, 32'(wb_cnt));
        if (UUT.u_sva.fail_cnt == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("%0d assertion failures", UUT.u_sva.fail_cnt);
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim/l1d_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module l1d_sva
    import l1d_pkg::*;
(
    input wire              clk_i,
    input wire              rstn_i,
    input wire              req_ready_o,
    input wire              rsp_valid_o,
    input wire [WORD_W-1:0] rsp_rdata_o,
    input wire              rsp_ready_i,
    input wire              mem_req_valid_o,
    input wire              mem_req_ready_i,
    input wire              mem_req_write_o,
    input wire [ADDR_W-1:0] mem_req_addr_o,
    input wire [LINE_W-1:0] mem_req_wdata_o
);

    int fail_cnt = 0;

    mem_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=>
            mem_req_valid_o && $stable(mem_req_write_o) && $stable(mem_req_addr_o)
            && $stable(mem_req_wdata_o))
        else begin
            fail_cnt++;
            $error("Memory request changed before it was accepted");
        end

    rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o))
        else begin
            fail_cnt++;
            $error("Core response changed before it was accepted");
        end

    // First cycle out of reset
    reset_idle: assert property (@(posedge clk_i)
        $rose(rstn_i) |-> req_ready_o && !rsp_valid_o && !mem_req_valid_o)
        else begin
            fail_cnt++;
            $error("Controller not idle after reset");
        end

endmodule

bind l1d_top l1d_sva u_sva (.*);

`default_nettype wire

/* sim/l1d_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module l1d_mem_model
    import l1d_pkg::*;
(
    input  wire               clk_i,
    input  wire               rstn_i,
    input  wire               mem_req_valid_i,
    output logic              mem_req_ready_o,
    input  wire               mem_req_write_i,
    input  wire  [ADDR_W-1:0] mem_req_addr_i,
    input  wire  [LINE_W-1:0] mem_req_wdata_i,
    output logic              mem_rsp_valid_o,
    output logic [LINE_W-1:0] mem_rsp_rdata_o,
    input  wire               mem_rsp_ready_i,

    // Observation ports for the testbench
    output logic [ADDR_W-1:0] refill_addr_o,
    output int                refill_cnt_o,
    output int                wb_cnt_o,
    input  wire  [ADDR_W-1:0] peek_addr_i,
    output logic [WORD_W-1:0] peek_word_o
);

    localparam int SLOTS = 256;

    logic [LINE_W-1:0] store_line [SLOTS];
    logic [ADDR_W-1:0] store_addr [SLOTS];
    logic              store_vld  [SLOTS];
    logic              rd_pend_q;
    int                delay_q;
    logic [ADDR_W-1:0] rd_addr_q;
    logic [LINE_W-1:0] peek_line;
    int                seed = 91;

    // Written lines come from the store, all others from the fill pattern
    function automatic logic [LINE_W-1:0] line_at(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] base;
        logic [7:0]        slot;
        logic [LINE_W-1:0] line;
        base = {addr[ADDR_W-1:4], 4'h0};
        slot = addr[11:4];
        if (store_vld[slot] && (store_addr[slot] == base)) begin
            return store_line[slot];
        end
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            line[w*WORD_W +: WORD_W] = (base + 4 * w) ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    assign mem_req_ready_o = 1'b1;

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < SLOTS; s++) begin
                store_vld[s] <= 1'b0;
            end
            rd_pend_q       <= 1'b0;
            delay_q         <= 0;
            mem_rsp_valid_o <= 1'b0;
            refill_addr_o   <= '0;
            refill_cnt_o    <= 0;
            wb_cnt_o        <= 0;
        end else begin
            if (mem_rsp_valid_o && mem_rsp_ready_i) begin
                mem_rsp_valid_o <= 1'b0;
            end
            if (rd_pend_q) begin
                if (delay_q == 1) begin
                    mem_rsp_valid_o <= 1'b1;
                    mem_rsp_rdata_o <= line_at(rd_addr_q);
                    rd_pend_q       <= 1'b0;
                end else begin
                    delay_q <= delay_q - 1;
                end
            end
            if (mem_req_valid_i && mem_req_ready_o) begin
                if (mem_req_write_i) begin
                    store_line[mem_req_addr_i[11:4]] <= mem_req_wdata_i;
                    store_addr[mem_req_addr_i[11:4]] <= mem_req_addr_i;
                    store_vld[mem_req_addr_i[11:4]]  <= 1'b1;
                    wb_cnt_o                         <= wb_cnt_o + 1;
                end else begin
                    rd_pend_q     <= 1'b1;
                    delay_q       <= 1 + ($unsigned($random(seed)) % 3);
                    rd_addr_q     <= mem_req_addr_i;
                    refill_addr_o <= mem_req_addr_i;
                    refill_cnt_o  <= refill_cnt_o + 1;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        peek_line   = line_at(peek_addr_i);
        peek_word_o <= peek_line[peek_addr_i[3:2]*WORD_W +: WORD_W];
    end

endmodule

`default_nettype wire

/* rtl/l1d_top.sv */
`timescale 1ns/1ps
`default_nettype none

module l1d_top
    import l1d_pkg::*;
(
    input  wire                clk_i,
    input  wire                rstn_i,

    input  wire                req_valid_i,
    output logic               req_ready_o,
    input  wire                req_write_i,
    input  wire  [ADDR_W-1:0]  req_addr_i,
    input  wire  [WORD_W-1:0]  req_wdata_i,
    output logic               rsp_valid_o,
    output logic [WORD_W-1:0]  rsp_rdata_o,
    input  wire                rsp_ready_i,

    output logic               mem_req_valid_o,
    input  wire                mem_req_ready_i,
    output logic               mem_req_write_o,
    output logic [ADDR_W-1:0]  mem_req_addr_o,
    output logic [LINE_W-1:0]  mem_req_wdata_o,
    input  wire                mem_rsp_valid_i,
    input  wire  [LINE_W-1:0]  mem_rsp_rdata_i,
    output logic               mem_rsp_ready_o
);

    logic               rd_en;
    logic [INDEX_W-1:0] rd_index;
    logic [TAG_W-1:0]   rd_tag;
    logic               wr_en;
    logic [WAY_W-1:0]   wr_way;
    logic [INDEX_W-1:0] wr_index;
    logic [TAG_W-1:0]   wr_tag;
    logic [LINE_W-1:0]  wr_line;
    logic               set_dirty;
    logic               refill_done;
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic [LINE_W-1:0]  hit_line;
    logic [WAY_W-1:0]   victim_way;
    logic               victim_dirty;
    logic [TAG_W-1:0]   victim_tag;
    logic [LINE_W-1:0]  victim_line;

    l1d_ctrl u_ctrl (
        .clk_i, .rstn_i,
        .req_valid_i, .req_ready_o, .req_write_i, .req_addr_i, .req_wdata_i,
        .rsp_valid_o, .rsp_rdata_o, .rsp_ready_i,
        .mem_req_valid_o, .mem_req_ready_i, .mem_req_write_o, .mem_req_addr_o,
        .mem_req_wdata_o, .mem_rsp_valid_i, .mem_rsp_rdata_i, .mem_rsp_ready_o,
        .hit_i(hit), .hit_way_i(hit_way), .hit_line_i(hit_line),
        .victim_way_i(victim_way), .victim_dirty_i(victim_dirty),
        .victim_tag_i(victim_tag), .victim_line_i(victim_line),
        .rd_en_o(rd_en), .rd_index_o(rd_index), .rd_tag_o(rd_tag),
        .wr_en_o(wr_en), .wr_way_o(wr_way), .wr_index_o(wr_index), .wr_tag_o(wr_tag),
        .wr_line_o(wr_line), .set_dirty_o(set_dirty), .refill_done_o(refill_done)
    );

    l1d_ways u_ways (
        .clk_i, .rstn_i,
        .rd_en_i(rd_en), .rd_index_i(rd_index), .rd_tag_i(rd_tag),
        .wr_en_i(wr_en), .wr_way_i(wr_way), .wr_index_i(wr_index), .wr_tag_i(wr_tag),
        .wr_line_i(wr_line), .set_dirty_i(set_dirty), .refill_done_i(refill_done),
        .hit_o(hit), .hit_way_o(hit_way), .hit_line_o(hit_line),
        .victim_way_o(victim_way), .victim_dirty_o(victim_dirty),
        .victim_tag_o(victim_tag), .victim_line_o(victim_line)
    );

endmodule

`default_nettype wire

/* rtl/l1d_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module l1d_ctrl
    import l1d_pkg::*;
(
    input  wire                clk_i,
    input  wire                rstn_i,

    input  wire                req_valid_i,
    output logic               req_ready_o,
    input  wire                req_write_i,
    input  wire  [ADDR_W-1:0]  req_addr_i,
    input  wire  [WORD_W-1:0]  req_wdata_i,
    output logic               rsp_valid_o,
    output logic [WORD_W-1:0]  rsp_rdata_o,
    input  wire                rsp_ready_i,

    output logic               mem_req_valid_o,
    input  wire                mem_req_ready_i,
    output logic               mem_req_write_o,
    output logic [ADDR_W-1:0]  mem_req_addr_o,
    output logic [LINE_W-1:0]  mem_req_wdata_o,
    input  wire                mem_rsp_valid_i,
    input  wire  [LINE_W-1:0]  mem_rsp_rdata_i,
    output logic               mem_rsp_ready_o,

    input  wire                hit_i,
    input  wire  [WAY_W-1:0]   hit_way_i,
    input  wire  [LINE_W-1:0]  hit_line_i,
    input  wire  [WAY_W-1:0]   victim_way_i,
    input  wire                victim_dirty_i,
    input  wire  [TAG_W-1:0]   victim_tag_i,
    input  wire  [LINE_W-1:0]  victim_line_i,

    output logic               rd_en_o,
    output logic [INDEX_W-1:0] rd_index_o,
    output logic [TAG_W-1:0]   rd_tag_o,
    output logic               wr_en_o,
    output logic [WAY_W-1:0]   wr_way_o,
    output logic [INDEX_W-1:0] wr_index_o,
    output logic [TAG_W-1:0]   wr_tag_o,
    output logic [LINE_W-1:0]  wr_line_o,
    output logic               set_dirty_o,
    output logic               refill_done_o
);

    l1d_state_e         state_q;
    l1d_state_e         state_d;
    logic               req_pend_q;
    logic               req_write_q;
    logic [ADDR_W-1:0]  req_addr_q;
    logic [WORD_W-1:0]  req_wdata_q;
    logic [WORD_W-1:0]  rsp_data_q;
    logic               req_fire;
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;
    logic [WSEL_W-1:0]  req_wsel;

    function automatic logic [LINE_W-1:0] merge_word(input logic [LINE_W-1:0] line,
                                                     input logic [WSEL_W-1:0] wsel,
                                                     input logic [WORD_W-1:0] data);
        logic [LINE_W-1:0] merged;
        merged = line;
        merged[wsel*WORD_W +: WORD_W] = data;
        return merged;
    endfunction

    assign req_tag   = addr_tag(req_addr_q);
    assign req_index = addr_index(req_addr_q);
    assign req_wsel  = addr_wsel(req_addr_q);

    // A captured request spends one IDLE cycle issuing the set read
    assign req_ready_o = (state_q == IDLE) && !req_pend_q;
    assign req_fire    = req_valid_i && req_ready_o;
    assign rd_en_o     = (state_q == IDLE) && req_pend_q;
    assign rd_index_o  = req_index;
    assign rd_tag_o    = req_tag;
    assign wr_index_o  = req_index;
    assign wr_tag_o    = req_tag;

    assign rsp_valid_o = (state_q == RESPOND);
    assign rsp_rdata_o = rsp_data_q;

    // Victim outputs stay put until the refill lands, so they drive the write-back directly
    assign mem_req_valid_o = (state_q == WRITEBACK) || (state_q == REFILL_REQ);
    assign mem_req_write_o = (state_q == WRITEBACK);
    assign mem_req_addr_o  = (state_q == WRITEBACK) ? line_addr(victim_tag_i, req_index)
                                                    : line_addr(req_tag, req_index);
    assign mem_req_wdata_o = victim_line_i;
    assign mem_rsp_ready_o = (state_q == REFILL_WAIT);

    always_comb begin
        state_d       = state_q;
        wr_en_o       = 1'b0;
        wr_way_o      = hit_way_i;
        wr_line_o     = merge_word(hit_line_i, req_wsel, req_wdata_q);
        set_dirty_o   = 1'b0;
        refill_done_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_pend_q) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit_i && req_write_q) begin
                    wr_en_o     = 1'b1;
                    set_dirty_o = 1'b1;
                    state_d     = IDLE;
                end else if (hit_i) begin
                    state_d = RESPOND;
                end else if (victim_dirty_i) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
            WRITEBACK: begin
                if (mem_req_ready_i) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (mem_req_ready_i) begin
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (mem_rsp_valid_i) begin
                    wr_en_o       = 1'b1;
                    wr_way_o      = victim_way_i;
                    wr_line_o     = req_write_q ? merge_word(mem_rsp_rdata_i, req_wsel, req_wdata_q)
                                                : mem_rsp_rdata_i;
                    set_dirty_o   = req_write_q;
                    refill_done_o = 1'b1;
                    state_d       = LOOKUP;
                end
            end
            RESPOND: begin
                if (rsp_ready_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q    <= IDLE;
            req_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (req_fire) begin
                req_pend_q <= 1'b1;
            end else if (rd_en_o) begin
                req_pend_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_write_q <= req_write_i;
            req_addr_q  <= req_addr_i;
            req_wdata_q <= req_wdata_i;
        end
        if ((state_q == LOOKUP) && hit_i && !req_write_q) begin
            rsp_data_q <= hit_line_i[req_wsel*WORD_W +: WORD_W];
        end
    end

endmodule

`default_nettype wire

/* rtl/l1d_ways.sv */
`timescale 1ns/1ps
`default_nettype none

module l1d_ways
    import l1d_pkg::*;
(
    input  wire                clk_i,
    input  wire                rstn_i,

    input  wire                rd_en_i,
    input  wire  [INDEX_W-1:0] rd_index_i,
    input  wire  [TAG_W-1:0]   rd_tag_i,

    input  wire                wr_en_i,
    input  wire  [WAY_W-1:0]   wr_way_i,
    input  wire  [INDEX_W-1:0] wr_index_i,
    input  wire  [TAG_W-1:0]   wr_tag_i,
    input  wire  [LINE_W-1:0]  wr_line_i,
    input  wire                set_dirty_i,
    input  wire                refill_done_i,

    output logic               hit_o,
    output logic [WAY_W-1:0]   hit_way_o,
    output logic [LINE_W-1:0]  hit_line_o,
    output logic [WAY_W-1:0]   victim_way_o,
    output logic               victim_dirty_o,
    output logic [TAG_W-1:0]   victim_tag_o,
    output logic [LINE_W-1:0]  victim_line_o
);

    logic [TAG_W-1:0]    tag_mem  [NUM_WAYS][NUM_SETS];
    logic [LINE_W-1:0]   line_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0] valid_q  [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q  [NUM_SETS];
    logic [INDEX_W-1:0]  rd_index_q;
    logic [TAG_W-1:0]    rd_tag_q;
    logic [WAY_W-1:0]    repl_q;

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_mem[wr_way_i][wr_index_i]  <= wr_tag_i;
            line_mem[wr_way_i][wr_index_i] <= wr_line_i;
        end
    end

    // Set address is captured once and held for the whole lookup and miss sequence
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_index_q <= rd_index_i;
            rd_tag_q   <= rd_tag_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            repl_q <= '0;
        end else begin
            if (refill_done_i) begin
                valid_q[wr_index_i][wr_way_i] <= 1'b1;
                dirty_q[wr_index_i][wr_way_i] <= set_dirty_i;
                repl_q                        <= repl_q + 1'b1;
            end else if (set_dirty_i) begin
                dirty_q[wr_index_i][wr_way_i] <= 1'b1;
            end
        end
    end

    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_q[rd_index_q][w] && (tag_mem[w][rd_index_q] == rd_tag_q)) begin
                hit_o     = 1'b1;
                hit_way_o = WAY_W'(w);
            end
        end
    end

    // Lowest invalid way wins, else the replacement pointer
    always_comb begin
        victim_way_o = repl_q;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[rd_index_q][w]) begin
                victim_way_o = WAY_W'(w);
            end
        end
    end

    assign hit_line_o     = line_mem[hit_way_o][rd_index_q];
    assign victim_dirty_o = dirty_q[rd_index_q][victim_way_o];
    assign victim_tag_o   = tag_mem[victim_way_o][rd_index_q];
    assign victim_line_o  = line_mem[victim_way_o][rd_index_q];

endmodule

`default_nettype wire

/* rtl/l1d_pkg.sv */
`default_nettype none

package l1d_pkg;

    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = WORDS_PER_LINE * WORD_W;
    localparam int NUM_SETS       = 8;
    localparam int NUM_WAYS       = 2;

    // Address split, low end first
    localparam int OFFSET_W = $clog2(WORD_W / 8);
    localparam int WSEL_W   = $clog2(WORDS_PER_LINE);
    localparam int INDEX_W  = $clog2(NUM_SETS);
    localparam int TAG_W    = ADDR_W - INDEX_W - WSEL_W - OFFSET_W;
    localparam int WAY_W    = $clog2(NUM_WAYS);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT,
        RESPOND
    } l1d_state_e;

    function automatic logic [TAG_W-1:0] addr_tag(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: TAG_W];
    endfunction

    function automatic logic [INDEX_W-1:0] addr_index(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W + WSEL_W +: INDEX_W];
    endfunction

    function automatic logic [WSEL_W-1:0] addr_wsel(input logic [ADDR_W-1:0] addr);
        return addr[OFFSET_W +: WSEL_W];
    endfunction

    // Line aligned address of a cached line
    function automatic logic [ADDR_W-1:0] line_addr(input logic [TAG_W-1:0] tag,
                                                    input logic [INDEX_W-1:0] index);
        return {tag, index, {(WSEL_W + OFFSET_W){1'b0}}};
    endfunction

endpackage

`default_nettype wire
